/* cpu8_top.f */
verilog/cpu8_pkg.sv
verilog/fetch_unit.sv
verilog/instr_buffer.sv
verilog/exec_unit.sv
verilog/wb_bus_master.sv
verilog/cpu8_top.sv
dv/tb_cpu8_top.sv

/* dv/tb_cpu8_top.sv */
// Testbench for the cpu8 core with a Wishbone memory slave and a reference ISA model
`timescale 1ns/1ns
`default_nettype none

module tb_cpu8_top;

    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 4;
    localparam int TEST_CYCLES = 400;               // Budget for one program
    localparam int N_TESTS     = 6;

    logic              clk;
    logic              rst;
    cpu8_pkg::wb_req_t wb;
    cpu8_pkg::wb_rsp_t wb_in;

    logic [7:0]  mem [16];                          // Memory behind the bus
    logic [7:0]  prog [16];                         // Image for the next test
    logic [7:0]  ref_mem [16];                      // Final memory of the ISA model
    logic [7:0]  saved_mem [16];                    // Random-delay result of program 2
    logic [11:0] exp_wr [$];                        // Model stores as {adr, dat}
    logic [3:0]  exp_jmp [$];                       // Model jump targets in program order
    logic [3:0]  end_pc;                            // Address of the final self-jump
    int          jmp_idx;                           // Redirects seen since reset
    int          wr_idx;                            // Stores seen on the bus
    logic [31:0] lcg_state;
    logic        zero_delay;                        // Ack on the first cycle of stb
    logic        end_seen;                          // Final self-jump reached
    logic        first_pend;                        // First bus cycle still to come
    int          errs;
    int          n_pass;
    int          n_fail;
    logic        rst_at_edge;
    logic        pending;                           // Cycle seen, ack not yet given
    int          wait_left;
    logic        cap_we;
    logic [3:0]  cap_adr;
    logic [7:0]  cap_dat;
    int          last_rd;                           // Last read address or -1 after a write
    int          jump_arm;                          // 2 skip, 1 first read, 3 second read
    logic [3:0]  jump_tgt;

    cpu8_top #(
        .BUF_DEPTH (2)
    ) cpu8_top_inst (
        .clk   (clk),
        .rst   (rst),
        .wb    (wb),
        .wb_in (wb_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("FAIL t=%0t: %s", $time, msg);
            errs++;
        end
    endtask

    // Latches a new bus cycle and checks where it goes
    task automatic start_cycle();
        pending   = 1'b1;
        cap_we    = wb.we;
        cap_adr   = wb.adr;
        cap_dat   = wb.dat_w;
        lcg_state = lcg_step(lcg_state);
        wait_left = zero_delay ? 0 : int'(lcg_state[17:16]) + 1;  // 1 to 4 wait states
        if (first_pend) begin
            expect_true(!wb.we && wb.adr == 4'h0, "first bus cycle is not a read of 0");
            first_pend = 1'b0;
        end
        if (jump_arm == 1) begin
            jump_arm = (!wb.we && wb.adr == jump_tgt) ? 0 : 3;  // One discarded read allowed
        end else if (jump_arm == 3) begin
            expect_true(!wb.we && wb.adr == jump_tgt,
                        $sformatf("read after jump at %h, target %h", wb.adr, jump_tgt));
            jump_arm = 0;
        end
    endtask

    task automatic serve_cycle();
        wb_in.ack = 1'b1;
        pending   = 1'b0;
        if (wb.we) begin
            mem[wb.adr] = wb.dat_w;
            expect_true(wr_idx < exp_wr.size() && {wb.adr, wb.dat_w} == exp_wr[wr_idx],
                        $sformatf("store %0d wrote %h to %h", wr_idx, wb.dat_w, wb.adr));
            wr_idx++;
            last_rd = -1;
        end else begin
            wb_in.dat_r = mem[wb.adr];
            if (last_rd == int'(wb.adr) && mem[wb.adr] == {4'h9, wb.adr}) end_seen = 1'b1;
            last_rd = int'(wb.adr);
        end
    endtask

    // Memory slave and bus checker that samples and drives 1 ns after each edge
    initial begin
        wb_in    = '0;
        pending  = 1'b0;
        last_rd  = -1;
        jump_arm = 0;
        jmp_idx  = 0;
        forever begin
            @(posedge clk);
            rst_at_edge = rst;                      // Value the DUT saw on this edge
            #1;
            expect_true(wb.cyc == wb.stb, "cyc and stb differ");
            if (rst_at_edge) begin
                expect_true(!wb.cyc, "bus active during reset");
                wb_in.ack = 1'b0;
                pending   = 1'b0;
                last_rd   = -1;
                jump_arm  = 0;
                jmp_idx   = 0;
            end else if (wb_in.ack) begin
                wb_in.ack = 1'b0;                   // Ack lasts one cycle
                expect_true(!wb.cyc, "no idle cycle after ack");
            end else if (wb.cyc) begin
                if (!pending) begin
                    start_cycle();
                end else begin
                    expect_true(wb.we == cap_we && wb.adr == cap_adr && wb.dat_w == cap_dat,
                                "we, adr or dat_w changed before ack");
                end
                if (wait_left == 0) serve_cycle();
                else wait_left--;
            end
            if (jump_arm == 2) jump_arm = 1;        // A read started on the jump edge may be stale
            if (!rst_at_edge && cpu8_top_inst.redirect) begin
                jump_arm = 2;
                jump_tgt = (jmp_idx < exp_jmp.size()) ? exp_jmp[jmp_idx] : end_pc;
                jmp_idx++;
            end
        end
    end

    // Reference ISA model that runs prog up to the self-jump
    task automatic run_model();
        logic [7:0] r [4];
        logic [3:0] pc;
        logic [3:0] op;
        logic [3:0] opd;
        logic [7:0] a;
        logic [7:0] b;
        exp_wr.delete();
        exp_jmp.delete();
        for (int i = 0; i < 4; i++) r[i] = 8'h00;
        for (int i = 0; i < 16; i++) ref_mem[i] = prog[i];
        pc = 4'h0;
        for (int step = 0; step < 100; step++) begin
            op  = ref_mem[pc][7:4];
            opd = ref_mem[pc][3:0];
            if (op == 4'h9 && opd == pc) break;
            a  = r[opd[3:2]];
            b  = r[opd[1:0]];
            pc = pc + 4'd1;                         // 16-word wrap
            case (op)
                4'h1, 4'h2, 4'h3, 4'h4: r[2'(op - 4'd1)] = ref_mem[opd];
                4'h5, 4'h6, 4'h7, 4'h8: begin
                    ref_mem[opd] = r[2'(op - 4'd5)];
                    exp_wr.push_back({opd, r[2'(op - 4'd5)]});
                end
                4'h9: begin
                    pc = opd;
                    exp_jmp.push_back(opd);
                end
                4'hA: r[opd[3:2]] = a + b;
                4'hB: r[opd[3:2]] = a - b;          // Mod 256
                4'hC: r[opd[3:2]] = a & b;
                4'hD: r[opd[3:2]] = a | b;
                4'hE: r[opd[3:2]] = (a < b) ? 8'd1 : 8'd0;
                4'hF: r[opd[3:2]] = (a == b) ? 8'd1 : 8'd0;
                default: ;                          // NOP
            endcase
        end
        end_pc = pc;                                // Self-jump keeps redirecting here
    endtask

    task automatic select_program(input int n);
        case (n)
            1: prog = '{8'h1F, 8'h5E, 8'h92, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
                        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h5A};
            2: prog = '{8'h1D, 8'h2E, 8'h3D, 8'hB9, 8'hA4, 8'hC1, 8'h6C, 8'hD6,
                        8'h5D, 8'h7E, 8'h6F, 8'h9B, 8'h00, 8'h3C, 8'h5A, 8'h00};
            3: prog = '{8'h1E, 8'h2F, 8'hE8, 8'hE4, 8'hFD, 8'hF2, 8'h5B, 8'h6C,
                        8'h7D, 8'h8E, 8'h9A, 8'h77, 8'h77, 8'h77, 8'h20, 8'h90};
            4: prog = '{8'h1F, 8'h98, 8'h5E, 8'h5E, 8'h5E, 8'h5E, 8'h5E, 8'h5E,
                        8'h5D, 8'h99, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h33};
            default: prog = '{8'h1F, 8'hA0, 8'h5E, 8'hA0, 8'h5E, 8'h2E, 8'hA5, 8'h6D,
                              8'h5C, 8'h6E, 8'h9A, 8'h00, 8'h00, 8'h00, 8'h00, 8'h11};
        endcase
    endtask

    task automatic run_test(input int num, input string name, input logic zd);
        int cycles;
        int errs_start;
        @(posedge clk);
        #1 rst = 1'b1;
        @(posedge clk);
        #1;
        errs_start = errs;
        for (int i = 0; i < 16; i++) mem[i] = prog[i];
        zero_delay = zd;
        run_model();
        wr_idx     = 0;
        end_seen   = 1'b0;
        first_pend = 1'b1;
        repeat (RST_CYCLES - 1) @(posedge clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (!end_seen && cycles < TEST_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!end_seen) begin
            $display("Test %0d never reached its final jump in %0d cycles", num, TEST_CYCLES);
            errs++;
        end
        for (int i = 0; i < 16; i++) begin
            expect_true(mem[i] == ref_mem[i],
                        $sformatf("mem[%h] is %h, model gives %h", i[3:0], mem[i], ref_mem[i]));
            if (zd) expect_true(mem[i] == saved_mem[i],
                                $sformatf("mem[%h] differs from the random-delay run", i[3:0]));
        end
        expect_true(wr_idx == exp_wr.size(),
                    $sformatf("%0d stores on the bus, model gives %0d", wr_idx, exp_wr.size()));
        if (errs == errs_start) begin
            n_pass++;
            $display("test %0d %s: pass", num, name);
        end else begin
            n_fail++;
            $display("test %0d %s: fail with %0d errors", num, name, errs - errs_start);
        end
    endtask

    initial begin
        rst        = 1'b1;
        lcg_state  = 32'hbf72;
        zero_delay = 1'b0;
        end_seen   = 1'b0;
        first_pend = 1'b0;
        wr_idx     = 0;
        errs       = 0;
        n_pass     = 0;
        n_fail     = 0;
        select_program(1);
        run_test(1, "reset and first access", 1'b0);
        select_program(2);
        run_test(2, "loads, stores and arithmetic", 1'b0);
        for (int i = 0; i < 16; i++) saved_mem[i] = mem[i];
        select_program(3);
        run_test(3, "comparisons", 1'b0);
        select_program(4);
        run_test(4, "jump", 1'b0);
        select_program(2);
        run_test(5, "zero-delay rerun of program 2", 1'b1);
        select_program(6);
        run_test(6, "store ordering", 1'b0);
        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog over all tests
    initial begin
        #(N_TESTS * (TEST_CYCLES + RST_CYCLES + 4) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the cpu8 testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu8_top \
    -f cpu8_top.f \
    -o sim_cpu8

./obj_dir/sim_cpu8 | tee sim.log

if grep -qxF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verilog/cpu8_pkg.sv */
// cpu8 shared package with widths, opcodes and the bus and instruction structs
`default_nettype none

package cpu8_pkg;

    parameter int ADDR_W = 4;                   // Memory address width, set by the operand nibble
    parameter int DATA_W = 8;                   // Data and instruction width
    parameter int REG_N  = 4;                   // Registers in the register file

    // Upper nibble of each instruction byte
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_LD0, OP_LD1, OP_LD2, OP_LD3,         // Memory to register
        OP_ST0, OP_ST1, OP_ST2, OP_ST3,         // Register to memory
        OP_JMP,                                 // PC takes the operand
        OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_LT, OP_EQ                            // Compares write 1 or 0
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] operand;                    // Address, jump target, or a and b selects
    } instr_t;

    // One requester's access, held until done
    typedef struct packed {
        logic              valid;
        logic              we;                  // High for a store
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;                 // Store data
    } mem_req_t;

    typedef struct packed {
        logic              done;                // One-cycle completion pulse
        logic [DATA_W-1:0] dat;                 // Read data, valid with done
    } mem_rsp_t;

    // Wishbone classic master side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat_w;
    } wb_req_t;

    // Wishbone classic slave side
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/cpu8_top.sv */
// cpu8 core top level joining fetch, queue, execute and the Wishbone master
`timescale 1ns/1ns
`default_nettype none

module cpu8_top #(
    parameter int BUF_DEPTH = 2                 // Instruction queue depth
) (
    input  wire                     clk,
    input  wire                     rst,
    output cpu8_pkg::wb_req_t       wb,
    input  wire cpu8_pkg::wb_rsp_t  wb_in
);
    cpu8_pkg::mem_req_t          fetch_req;
    cpu8_pkg::mem_rsp_t          fetch_rsp;
    cpu8_pkg::mem_req_t          exec_req;
    cpu8_pkg::mem_rsp_t          exec_rsp;
    logic                        push_valid;
    cpu8_pkg::instr_t            push_data;
    logic                        push_ready;
    logic                        pop_valid;
    cpu8_pkg::instr_t            pop_data;
    logic                        pop_ready;
    logic                        redirect;      // Jump from execute
    logic [cpu8_pkg::ADDR_W-1:0] redirect_pc;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req         (fetch_req),
        .rsp         (fetch_rsp),
        .push_valid  (push_valid),
        .push_data   (push_data),
        .push_ready  (push_ready)
    );

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) instr_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready),
        .flush      (redirect)                  // Queued bytes are past the jump
    );

    exec_unit exec_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .pop_valid   (pop_valid),
        .pop_data    (pop_data),
        .pop_ready   (pop_ready),
        .req         (exec_req),
        .rsp         (exec_rsp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    wb_bus_master wb_bus_master_inst (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .exec_req  (exec_req),
        .exec_rsp  (exec_rsp),
        .wb        (wb),
        .wb_in     (wb_in)
    );

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
// Execute unit with decode, register file, ALU, load and store requests and jumps
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pop_valid,
    input  wire cpu8_pkg::instr_t       pop_data,
    output logic                        pop_ready,
    output cpu8_pkg::mem_req_t          req,
    input  wire cpu8_pkg::mem_rsp_t     rsp,
    output logic                        redirect,   // One-cycle jump strobe
    output logic [cpu8_pkg::ADDR_W-1:0] redirect_pc
);
    logic [cpu8_pkg::DATA_W-1:0] regs [cpu8_pkg::REG_N];
    logic                        busy;          // Load or store on the bus
    cpu8_pkg::instr_t            cur;           // Held load or store
    logic [3:0]                  op_m1;         // Opcode minus one, bit 2 marks a store
    logic                        fire;          // Instruction popped this cycle
    logic                        is_mem;
    logic                        is_alu;
    logic [cpu8_pkg::DATA_W-1:0] op_a;
    logic [cpu8_pkg::DATA_W-1:0] op_b;
    logic [cpu8_pkg::DATA_W-1:0] alu_res;

    assign pop_ready   = !busy;                 // Stall the queue while memory is out
    assign fire        = pop_valid && pop_ready;
    assign is_mem      = pop_data.opcode inside {[cpu8_pkg::OP_LD0:cpu8_pkg::OP_ST3]};
    assign is_alu      = pop_data.opcode inside {[cpu8_pkg::OP_ADD:cpu8_pkg::OP_EQ]};
    assign redirect    = fire && (pop_data.opcode == cpu8_pkg::OP_JMP);
    assign redirect_pc = pop_data.operand;

    // Operand bits 3:2 pick a, bits 1:0 pick b
    assign op_a = regs[pop_data.operand[3:2]];
    assign op_b = regs[pop_data.operand[1:0]];

    always_comb begin
        alu_res = '0;
        case (pop_data.opcode)
            cpu8_pkg::OP_ADD: alu_res = op_a + op_b;
            cpu8_pkg::OP_SUB: alu_res = op_a - op_b;     // Wraps modulo 256
            cpu8_pkg::OP_AND: alu_res = op_a & op_b;
            cpu8_pkg::OP_OR:  alu_res = op_a | op_b;
            cpu8_pkg::OP_LT:  alu_res[0] = (op_a < op_b);  // Unsigned
            cpu8_pkg::OP_EQ:  alu_res[0] = (op_a == op_b);
            default:          alu_res = op_a;
        endcase
    end

    // LD0..LD3 give 0..3, ST0..ST3 give 4..7
    assign op_m1 = cur.opcode - 4'd1;

    always_comb begin
        req.valid = busy;
        req.we    = op_m1[2];
        req.adr   = cur.operand;
        req.dat   = regs[op_m1[1:0]];           // Stable, no register write while busy
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            for (int i = 0; i < cpu8_pkg::REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (busy) begin
            if (rsp.done) begin
                busy <= 1'b0;
                if (!op_m1[2]) regs[op_m1[1:0]] <= rsp.dat;  // Load result
            end
        end else if (fire) begin
            if (is_mem) busy <= 1'b1;
            if (is_alu) regs[pop_data.operand[3:2]] <= alu_res;  // Result to a
        end
    end

    always_ff @(posedge clk) begin
        if (fire) cur <= pop_data;
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
// Fetch unit that reads instruction bytes at the PC and pushes them to the queue
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         redirect,       // Jump taken in execute
    input  wire [cpu8_pkg::ADDR_W-1:0]  redirect_pc,
    output cpu8_pkg::mem_req_t          req,
    input  wire cpu8_pkg::mem_rsp_t     rsp,
    output logic                        push_valid,
    output cpu8_pkg::instr_t            push_data,
    input  wire                         push_ready
);
    logic [cpu8_pkg::ADDR_W-1:0] pc;            // Address of the next byte to fetch
    logic [cpu8_pkg::ADDR_W-1:0] rd_adr;        // Address of the read on the bus
    logic                        rd_pend;       // Read outstanding
    logic                        stale;         // Outstanding read was overtaken by a jump
    logic                        hold_valid;    // Fetched byte waiting for queue space
    cpu8_pkg::instr_t            hold_data;
    logic                        got;           // Wanted byte arrives this cycle

    assign got        = rd_pend && rsp.done && !stale;
    assign push_valid = hold_valid || got;
    assign push_data  = hold_valid ? hold_data : cpu8_pkg::instr_t'(rsp.dat);

    always_comb begin
        req.valid = rd_pend;
        req.we    = 1'b0;                       // Fetch only reads
        req.adr   = rd_adr;
        req.dat   = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            rd_pend    <= 1'b0;
            stale      <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (rd_pend && rsp.done) begin
                rd_pend <= 1'b0;                // Next read no earlier than the following cycle
            end else if (!rd_pend && !hold_valid && !redirect) begin
                rd_pend <= 1'b1;
            end
            if (redirect) begin
                stale <= rd_pend && !rsp.done;  // Let the bus finish, drop the byte
            end else if (rsp.done) begin
                stale <= 1'b0;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end else if (got) begin
                pc <= pc + 1'b1;                // Wraps modulo 16
            end
            if (redirect) begin
                hold_valid <= 1'b0;             // Held byte is from the old path
            end else if (got && !push_ready) begin
                hold_valid <= 1'b1;
            end else if (push_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rd_pend) rd_adr <= pc;             // Frozen while the read is out
        if (got && !push_ready) hold_data <= cpu8_pkg::instr_t'(rsp.dat);
    end

endmodule

`default_nettype wire

/* verilog/instr_buffer.sv */
// Instruction queue between fetch and execute, emptied on a taken jump
`timescale 1ns/1ns
`default_nettype none

module instr_buffer #(
    parameter int BUF_DEPTH = 2                 // Entries, 2 or more
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     push_valid,
    input  wire cpu8_pkg::instr_t   push_data,
    output logic                    push_ready,
    output logic                    pop_valid,
    output cpu8_pkg::instr_t        pop_data,
    input  wire                     pop_ready,
    input  wire                     flush           // Jump redirect
);
    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    cpu8_pkg::instr_t mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != CNT_W'(BUF_DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];            // Head entry
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin                 // Flush beats a push on the same edge
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

/* verilog/wb_bus_master.sv */
// Wishbone classic master that serves the fetch and execute requesters, execute first
`timescale 1ns/1ns
`default_nettype none

module wb_bus_master (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cpu8_pkg::mem_req_t  fetch_req,
    output cpu8_pkg::mem_rsp_t       fetch_rsp,
    input  wire cpu8_pkg::mem_req_t  exec_req,
    output cpu8_pkg::mem_rsp_t       exec_rsp,
    output cpu8_pkg::wb_req_t        wb,
    input  wire cpu8_pkg::wb_rsp_t   wb_in
);
    typedef enum logic [1:0] {
        S_IDLE,                                 // Waiting for a request
        S_ACTIVE,                               // cyc and stb up, waiting for ack
        S_GAP                                   // Idle cycle after ack
    } state_e;

    state_e                      state;
    logic                        owner_exec;    // Execute holds the bus
    cpu8_pkg::mem_req_t          sel_req;       // Request that wins in idle
    logic                        we_q;
    logic [cpu8_pkg::ADDR_W-1:0] adr_q;
    logic [cpu8_pkg::DATA_W-1:0] dat_q;
    logic                        ack_now;

    assign sel_req = exec_req.valid ? exec_req : fetch_req;
    assign ack_now = (state == S_ACTIVE) && wb_in.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            owner_exec <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (exec_req.valid || fetch_req.valid) begin
                        state      <= S_ACTIVE;
                        owner_exec <= exec_req.valid;
                    end
                end
                S_ACTIVE: if (wb_in.ack) state <= S_GAP;  // Slave may stall here
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Bus fields captured at grant and held through the cycle
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            we_q  <= sel_req.we;
            adr_q <= sel_req.adr;
            dat_q <= sel_req.dat;
        end
    end

    always_comb begin
        wb.cyc   = (state == S_ACTIVE);
        wb.stb   = (state == S_ACTIVE);
        wb.we    = we_q;
        wb.adr   = adr_q;
        wb.dat_w = dat_q;
    end

    // Ack goes back as done to the owner only
    always_comb begin
        exec_rsp.done  = ack_now && owner_exec;
        exec_rsp.dat   = wb_in.dat_r;
        fetch_rsp.done = ack_now && !owner_exec;
        fetch_rsp.dat  = wb_in.dat_r;
    end

endmodule

`default_nettype wire
